//--- src.f
+incdir+.
ex_op_pkg.sv
mem_access_pkg.sv
alu.sv
multiplier.sv
divider.sv
addr_translate.sv
ex_stage.sv
tb_ex_stage.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ex_stage -f src.f -o sim_ex_stage
./obj_dir/sim_ex_stage > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- tb_ex_stage.sv
`default_nettype none
`timescale 1ns/100ps
`include "ex_consts.svh"

module tb_ex_stage;

    import ex_op_pkg::*;
    import mem_access_pkg::*;

    localparam logic [1:0] ENV_DA      = 2'd0;
    localparam logic [1:0] ENV_PG      = 2'd1;
    localparam logic [1:0] ENV_PG_BOTH = 2'd2;

    localparam logic [1:0] CTRL_NONE  = 2'd0;
    localparam logic [1:0] CTRL_FLUSH = 2'd1;
    localparam logic [1:0] CTRL_HOLD  = 2'd2;

    typedef struct packed {
        alu_op_t              alu_op;
        mul_op_t              mul_op;
        div_op_t              div_op;
        mem_kind_t            mem_kind;
        logic [`EX_XLEN-1:0]  src1;
        logic [`EX_XLEN-1:0]  src2;
        logic [`EX_XLEN-1:0]  store_value;
        logic [`EX_XLEN-1:0]  crmd;
        logic [`EX_XLEN-1:0]  dmw0;
        logic [`EX_XLEN-1:0]  dmw1;
        logic [`EX_XLEN-1:0]  exp_result;
        ex_code_t             exp_except;
        logic [1:0]           ctrl;
    } entry_t;

    logic                   clk;
    logic                   reset;
    logic                   flush;
    logic                   in_valid;
    alu_op_t                alu_op;
    mul_op_t                mul_op;
    div_op_t                div_op;
    mem_kind_t              mem_kind;
    logic [`EX_XLEN-1:0]    src1;
    logic [`EX_XLEN-1:0]    src2;
    logic [`EX_XLEN-1:0]    store_value;
    logic [`EX_XLEN-1:0]    csr_crmd;
    logic [`EX_XLEN-1:0]    csr_dmw0;
    logic [`EX_XLEN-1:0]    csr_dmw1;
    logic                   mem_allow_in;
    logic                   allow_in;
    logic                   data_sram_req;
    logic                   data_sram_wr;
    mem_size_t              data_sram_size;
    logic [`EX_XLEN-1:0]    data_sram_addr;
    logic [`EX_XLEN/8-1:0]  data_sram_wstrb;
    logic [`EX_XLEN-1:0]    data_sram_wdata;
    logic                   data_sram_addr_ok;
    logic                   out_valid;
    logic [`EX_XLEN-1:0]    out_result;
    ex_code_t               out_except;
    logic [`EX_XLEN-1:0]    out_badv;

    entry_t entries[$];
    string  names[$];
    int     cycle_count;
    int     cycle_limit;

    ex_stage DUT (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("mismatch %s %s expected %h actual %h", test, field, expected, actual);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_true(input string test, input logic cond, input string what);
        assert (cond) else begin
            $display("%s: %s", test, what);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic add_entry(input string name, input alu_op_t a, input mul_op_t m,
                             input div_op_t d, input mem_kind_t k,
                             input logic [31:0] s1, input logic [31:0] s2,
                             input logic [31:0] sv, input logic [1:0] env,
                             input logic [31:0] res, input ex_code_t exc,
                             input logic [1:0] ctrl);
        entry_t e;
        e.alu_op = a;
        e.mul_op = m;
        e.div_op = d;
        e.mem_kind = k;
        e.src1 = s1;
        e.src2 = s2;
        e.store_value = sv;
        // DMW0 maps 0xa... to 0x0..., DMW1 maps 0x8... to 0x2... or overlaps DMW0
        e.crmd = (env == ENV_DA) ? 32'h0000_0008 : 32'h0000_0010;
        e.dmw0 = (env == ENV_DA) ? 32'h0 : 32'ha000_0001;
        e.dmw1 = (env == ENV_PG_BOTH) ? 32'ha400_0001 : (env == ENV_PG) ? 32'h8200_0001 : 32'h0;
        e.exp_result = res;
        e.exp_except = exc;
        e.ctrl = ctrl;
        names.push_back(name);
        entries.push_back(e);
    endtask

    task automatic add_alu(input string name, input alu_op_t op, input logic [31:0] s1,
                           input logic [31:0] s2, input logic [31:0] res);
        add_entry(name, op, MUL_NONE, DIV_NONE, MEM_NONE, s1, s2, 32'h0, ENV_DA, res,
                  EXC_NONE, CTRL_NONE);
    endtask

    task automatic add_mul(input string name, input mul_op_t op, input logic [31:0] s1,
                           input logic [31:0] s2, input logic [31:0] res);
        add_entry(name, ALU_ADD, op, DIV_NONE, MEM_NONE, s1, s2, 32'h0, ENV_DA, res,
                  EXC_NONE, CTRL_NONE);
    endtask

    task automatic add_div(input string name, input div_op_t op, input logic [31:0] s1,
                           input logic [31:0] s2, input logic [31:0] res,
                           input logic [1:0] ctrl);
        add_entry(name, ALU_ADD, MUL_NONE, op, MEM_NONE, s1, s2, 32'h0, ENV_DA, res,
                  EXC_NONE, ctrl);
    endtask

    // The address is the ALU sum, which is also the reported result
    task automatic add_mem(input string name, input mem_kind_t kind, input logic [31:0] s1,
                           input logic [31:0] s2, input logic [31:0] sv,
                           input logic [1:0] env, input ex_code_t exc,
                           input logic [1:0] ctrl);
        add_entry(name, ALU_ADD, MUL_NONE, DIV_NONE, kind, s1, s2, sv, env, s1 + s2, exc, ctrl);
    endtask

    task automatic build_table();
        add_alu("add", ALU_ADD, 32'd5, 32'd7, 32'd12);
        add_alu("sub", ALU_SUB, 32'd5, 32'd7, 32'hffff_fffe);
        add_alu("slt", ALU_SLT, 32'hffff_ffff, 32'h1, 32'h1);
        add_alu("sltu", ALU_SLTU, 32'hffff_ffff, 32'h1, 32'h0);
        add_alu("and", ALU_AND, 32'hf0f0_f0f0, 32'hff00_ff00, 32'hf000_f000);
        add_alu("or", ALU_OR, 32'hf0f0_f0f0, 32'h0ff0_0000, 32'hfff0_f0f0);
        add_alu("nor", ALU_NOR, 32'hf0f0_0000, 32'h00f0_f0f0, 32'h0f0f_0f0f);
        add_alu("xor", ALU_XOR, 32'hff00_ff00, 32'h0ff0_0ff0, 32'hf0f0_f0f0);
        add_alu("sll", ALU_SLL, 32'h1, 32'h1f, 32'h8000_0000);
        add_alu("sll_low_bits", ALU_SLL, 32'h1234_5678, 32'hffff_ffe4, 32'h2345_6780);
        add_alu("srl", ALU_SRL, 32'h8000_0000, 32'h4, 32'h0800_0000);
        add_alu("sra", ALU_SRA, 32'h8000_0000, 32'h4, 32'hf800_0000);
        add_alu("lu12i", ALU_LU12I, 32'h1234_5678, 32'habcd_e000, 32'habcd_e000);
        add_mul("mul", MUL_LO, 32'hffff_fffd, 32'h7, 32'hffff_ffeb);
        add_mul("mulh_small", MUL_HI, 32'hffff_fffd, 32'h7, 32'hffff_ffff);
        add_mul("mulh", MUL_HI, 32'h8000_0000, 32'h7fff_ffff, 32'hc000_0000);
        add_mul("mulhu", MUL_HIU, 32'h8000_0000, 32'h7fff_ffff, 32'h3fff_ffff);
        add_div("div", DIV_DIV, 32'hffff_fff9, 32'h2, 32'hffff_fffd, CTRL_NONE);
        add_div("mod", DIV_MOD, 32'hffff_fff9, 32'h2, 32'hffff_ffff, CTRL_NONE);
        add_div("divu", DIV_DIVU, 32'hffff_fff9, 32'h2, 32'h7fff_fffc, CTRL_NONE);
        add_div("modu", DIV_MODU, 32'hffff_fff9, 32'h2, 32'h1, CTRL_NONE);
        add_div("div_neg_divisor", DIV_DIV, 32'd100, 32'hffff_fff9, 32'hffff_fff2, CTRL_NONE);
        add_div("mod_neg_divisor", DIV_MOD, 32'd100, 32'hffff_fff9, 32'h2, CTRL_NONE);
        add_div("div_by_zero", DIV_DIV, 32'hedcb_a988, 32'h0, 32'hffff_ffff, CTRL_NONE);
        add_div("mod_by_zero", DIV_MOD, 32'hffff_fffb, 32'h0, 32'hffff_fffb, CTRL_NONE);
        add_div("div_flushed", DIV_DIV, 32'd100, 32'd7, 32'd14, CTRL_FLUSH);
        add_alu("add_after_flush", ALU_ADD, 32'h100, 32'h23, 32'h123);
        add_mem("st_w", MEM_ST_W, 32'h1000, 32'h4, 32'hdead_beef, ENV_DA, EXC_NONE, CTRL_NONE);
        add_mem("st_h_high", MEM_ST_H, 32'h1000, 32'h6, 32'h1234_abcd, ENV_DA, EXC_NONE,
                CTRL_NONE);
        add_mem("st_h_low", MEM_ST_H, 32'h1000, 32'h0, 32'h1234_abcd, ENV_DA, EXC_NONE,
                CTRL_NONE);
        add_mem("st_b_3", MEM_ST_B, 32'h1000, 32'h3, 32'h0000_00a5, ENV_DA, EXC_NONE, CTRL_NONE);
        add_mem("st_b_1", MEM_ST_B, 32'h1000, 32'h1, 32'h0000_003c, ENV_DA, EXC_NONE, CTRL_NONE);
        add_mem("ld_w", MEM_LD_W, 32'h2000, 32'h0, 32'h0, ENV_DA, EXC_NONE, CTRL_NONE);
        add_mem("ld_bu", MEM_LD_BU, 32'h2000, 32'h2, 32'h0, ENV_DA, EXC_NONE, CTRL_NONE);
        add_mem("ld_h_ale", MEM_LD_H, 32'h2000, 32'h1, 32'h0, ENV_DA, EXC_ALE, CTRL_NONE);
        add_mem("ld_w_ale", MEM_LD_W, 32'h2000, 32'h2, 32'h0, ENV_DA, EXC_ALE, CTRL_NONE);
        add_mem("st_w_ale", MEM_ST_W, 32'h2000, 32'h3, 32'h5555_aaaa, ENV_DA, EXC_ALE,
                CTRL_NONE);
        add_mem("st_w_held", MEM_ST_W, 32'h3000, 32'h8, 32'h0102_0304, ENV_DA, EXC_NONE,
                CTRL_HOLD);
        add_mem("ld_w_dmw0", MEM_LD_W, 32'ha000_0000, 32'h100, 32'h0, ENV_PG, EXC_NONE,
                CTRL_NONE);
        add_mem("st_w_dmw1", MEM_ST_W, 32'h8000_0000, 32'h200, 32'hcafe_f00d, ENV_PG, EXC_NONE,
                CTRL_NONE);
        add_mem("st_b_dmw1", MEM_ST_B, 32'h8000_0000, 32'h7, 32'h0000_0077, ENV_PG, EXC_NONE,
                CTRL_NONE);
        add_mem("ld_w_tlbr", MEM_LD_W, 32'h4000_0000, 32'h0, 32'h0, ENV_PG, EXC_TLBR, CTRL_NONE);
        add_mem("ld_w_both_windows", MEM_LD_W, 32'ha000_1000, 32'h0, 32'h0, ENV_PG_BOTH,
                EXC_NONE, CTRL_NONE);
        add_mem("ale_before_tlbr", MEM_LD_W, 32'h4000_0000, 32'h2, 32'h0, ENV_PG, EXC_ALE,
                CTRL_NONE);
    endtask

    function automatic logic window_hit(input logic [31:0] dmw, input logic [31:0] va,
                                        input logic [1:0] plv);
        logic plv_ok;
        plv_ok = (plv == 2'd0 && dmw[`EX_DMW_PLV0]) || (plv == 2'd3 && dmw[`EX_DMW_PLV3]);
        return plv_ok && (dmw[`EX_DMW_VSEG_LSB +: 3] == va[31:29]);
    endfunction

    // Reference model of the SRAM request for an access without exception
    task automatic expect_sram(input entry_t e, output logic [31:0] pa,
                               output logic [3:0] wstrb, output logic [31:0] wdata,
                               output mem_size_t size);
        logic [31:0] va;
        logic [1:0]  plv;
        int          nbytes;
        va = e.src1 + e.src2;
        plv = e.crmd[`EX_CRMD_PLV_LSB +: 2];
        pa = va;
        if (!e.crmd[`EX_CRMD_DA] || e.crmd[`EX_CRMD_PG]) begin
            if (window_hit(e.dmw0, va, plv))
                pa = {e.dmw0[`EX_DMW_PSEG_LSB +: 3], va[28:0]};
            else if (window_hit(e.dmw1, va, plv))
                pa = {e.dmw1[`EX_DMW_PSEG_LSB +: 3], va[28:0]};
        end
        case (e.mem_kind)
            MEM_LD_B, MEM_LD_BU, MEM_ST_B: size = SIZE_BYTE;
            MEM_LD_H, MEM_LD_HU, MEM_ST_H: size = SIZE_HALF;
            default:                       size = SIZE_WORD;
        endcase
        nbytes = (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
        // Lanes from the low address bits upward, data repeated every nbytes
        for (int b = 0; b < 4; b++) begin
            wstrb[b] = (b >= int'(va[1:0])) && (b < int'(va[1:0]) + nbytes);
            wdata[8*b +: 8] = e.store_value[8*(b % nbytes) +: 8];
        end
        if (e.mem_kind inside {MEM_LD_B, MEM_LD_BU, MEM_LD_H, MEM_LD_HU, MEM_LD_W})
            wstrb = 4'b0000;
    endtask

    task automatic drive_entry(input entry_t e);
        in_valid = 1'b1;
        alu_op = e.alu_op;
        mul_op = e.mul_op;
        div_op = e.div_op;
        mem_kind = e.mem_kind;
        src1 = e.src1;
        src2 = e.src2;
        store_value = e.store_value;
        csr_crmd = e.crmd;
        csr_dmw0 = e.dmw0;
        csr_dmw1 = e.dmw1;
        mem_allow_in = (e.ctrl != CTRL_HOLD);
        data_sram_addr_ok = 1'b0;
    endtask

    initial begin
        entry_t      e;
        logic [31:0] va;
        logic [31:0] exp_pa;
        logic [31:0] exp_wdata;
        logic [3:0]  exp_wstrb;
        mem_size_t   exp_size;
        logic        is_store;
        logic        wants_req;
        int          waited;
        int          latency;

        void'($urandom(32'h7daa32ce));
        clk = 1'b0;
        reset = 1'b1;
        flush = 1'b0;
        in_valid = 1'b0;
        alu_op = ALU_ADD;
        mul_op = MUL_NONE;
        div_op = DIV_NONE;
        mem_kind = MEM_NONE;
        src1 = '0;
        src2 = '0;
        store_value = '0;
        csr_crmd = 32'h0000_0008;
        csr_dmw0 = '0;
        csr_dmw1 = '0;
        mem_allow_in = 1'b1;
        data_sram_addr_ok = 1'b0;
        cycle_count = 0;
        build_table();
        cycle_limit = entries.size() * 40;

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < entries.size(); i++) begin
            e = entries[i];
            va = e.src1 + e.src2;
            is_store = e.mem_kind inside {MEM_ST_B, MEM_ST_H, MEM_ST_W};
            wants_req = (e.mem_kind != MEM_NONE) && (e.exp_except == EXC_NONE);
            expect_sram(e, exp_pa, exp_wstrb, exp_wdata, exp_size);
            latency = (e.div_op != DIV_NONE) ? 33 : (e.mul_op != MUL_NONE) ? 1 : 0;

            @(negedge clk);
            drive_entry(e);
            #1;
            check_true(names[i], allow_in, "stage is not ready to accept an instruction");
            @(negedge clk);
            in_valid = 1'b0;

            if (e.ctrl == CTRL_FLUSH) begin
                repeat (5) @(negedge clk);
                flush = 1'b1;
                @(negedge clk);
                flush = 1'b0;
                // Well past the point where the divide would have completed
                repeat (36) begin
                    #1;
                    check_true(names[i], !out_valid, "flushed divide still produced a result");
                    check_true(names[i], allow_in, "stage not empty after flush");
                    @(negedge clk);
                end
                continue;
            end

            if (e.ctrl == CTRL_HOLD) begin
                repeat (5) begin
                    data_sram_addr_ok = ($urandom_range(0, 1) != 0);
                    #1;
                    check_true(names[i], !data_sram_req, "SRAM request while next stage stalls");
                    check_true(names[i], !out_valid, "output valid while next stage stalls");
                    check_value(names[i], "held result", e.exp_result, out_result);
                    @(negedge clk);
                end
                mem_allow_in = 1'b1;
            end

            waited = 0;
            forever begin
                data_sram_addr_ok = ($urandom_range(0, 1) != 0);
                #1;
                if (wants_req) begin
                    check_true(names[i], data_sram_req, "no SRAM request for a memory access");
                    check_value(names[i], "addr", exp_pa, data_sram_addr);
                    check_value(names[i], "size", 32'(exp_size), 32'(data_sram_size));
                    check_value(names[i], "wr", 32'(is_store), 32'(data_sram_wr));
                    check_value(names[i], "wstrb", 32'(exp_wstrb), 32'(data_sram_wstrb));
                    if (is_store)
                        check_value(names[i], "wdata", exp_wdata, data_sram_wdata);
                end else begin
                    check_true(names[i], !data_sram_req, "unexpected SRAM request");
                end
                if (out_valid)
                    break;
                waited++;
                @(negedge clk);
            end

            if (!wants_req)
                check_value(names[i], "latency", latency, waited);
            check_value(names[i], "result", e.exp_result, out_result);
            check_value(names[i], "except", 32'(e.exp_except), 32'(out_except));
            if (e.exp_except != EXC_NONE)
                check_value(names[i], "badv", va, out_badv);
        end

        @(negedge clk);
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- ex_stage.sv
`default_nettype none
`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,
    input  logic                      in_valid,
    input  ex_op_pkg::alu_op_t        alu_op,
    input  ex_op_pkg::mul_op_t        mul_op,
    input  ex_op_pkg::div_op_t        div_op,
    input  mem_access_pkg::mem_kind_t mem_kind,
    input  logic [`EX_XLEN-1:0]       src1,
    input  logic [`EX_XLEN-1:0]       src2,
    input  logic [`EX_XLEN-1:0]       store_value,
    input  logic [`EX_XLEN-1:0]       csr_crmd,
    input  logic [`EX_XLEN-1:0]       csr_dmw0,
    input  logic [`EX_XLEN-1:0]       csr_dmw1,
    input  logic                      mem_allow_in,
    output logic                      allow_in,
    output logic                      data_sram_req,
    output logic                      data_sram_wr,
    output mem_access_pkg::mem_size_t data_sram_size,
    output logic [`EX_XLEN-1:0]       data_sram_addr,
    output logic [`EX_XLEN/8-1:0]     data_sram_wstrb,
    output logic [`EX_XLEN-1:0]       data_sram_wdata,
    input  logic                      data_sram_addr_ok,
    output logic                      out_valid,
    output logic [`EX_XLEN-1:0]       out_result,
    output mem_access_pkg::ex_code_t  out_except,
    output logic [`EX_XLEN-1:0]       out_badv
);

    import ex_op_pkg::*;
    import mem_access_pkg::*;

    logic                 valid;
    alu_op_t              alu_op_q;
    mul_op_t              mul_op_q;
    div_op_t              div_op_q;
    mem_kind_t            kind_q;
    logic [`EX_XLEN-1:0]  src1_q;
    logic [`EX_XLEN-1:0]  src2_q;
    logic [`EX_XLEN-1:0]  store_q;

    logic                 is_mul;
    logic                 is_div;
    logic                 is_mem;
    logic                 is_store;
    logic                 ready_go;
    logic                 mul_ready;
    logic                 div_started;
    logic                 div_finished;
    logic                 div_start;
    logic                 div_reset;
    logic                 div_done;
    logic                 misaligned;
    logic                 has_exc;
    logic [`EX_XLEN-1:0]  alu_result;
    logic [`EX_XLEN-1:0]  mul_result;
    logic [`EX_XLEN-1:0]  div_result;
    logic [`EX_XLEN-1:0]  pa;
    ex_code_t             tr_except;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid <= 1'b0;
        end else if (allow_in) begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && allow_in) begin
            alu_op_q <= alu_op;
            mul_op_q <= mul_op;
            div_op_q <= div_op;
            kind_q <= mem_kind;
            src1_q <= src1;
            src2_q <= src2;
            store_q <= store_value;
        end
    end

    // Per-instruction progress of the multi-cycle units
    always_ff @(posedge clk) begin
        if (reset || flush || allow_in) begin
            mul_ready <= 1'b0;
            div_started <= 1'b0;
            div_finished <= 1'b0;
        end else begin
            if (valid && is_mul)
                mul_ready <= 1'b1;
            if (div_start)
                div_started <= 1'b1;
            if (div_done)
                div_finished <= 1'b1;
        end
    end

    assign is_mul = (mul_op_q != MUL_NONE);
    assign is_div = (div_op_q != DIV_NONE);
    assign is_mem = (kind_q != MEM_NONE);
    assign is_store = (kind_q == MEM_ST_B) || (kind_q == MEM_ST_H) || (kind_q == MEM_ST_W);

    assign div_start = valid & is_div & ~div_started & ~flush;
    assign div_reset = reset | flush;

    alu u_alu (
        .alu_op (alu_op_q),
        .src1   (src1_q),
        .src2   (src2_q),
        .result (alu_result)
    );

    multiplier u_mul (
        .clk    (clk),
        .op     (mul_op_q),
        .src1   (src1_q),
        .src2   (src2_q),
        .result (mul_result)
    );

    divider u_div (
        .clk    (clk),
        .reset  (div_reset),
        .start  (div_start),
        .op     (div_op_q),
        .src1   (src1_q),
        .src2   (src2_q),
        .result (div_result),
        .done   (div_done)
    );

    addr_translate u_tr (
        .va       (alu_result),
        .csr_crmd (csr_crmd),
        .csr_dmw0 (csr_dmw0),
        .csr_dmw1 (csr_dmw1),
        .pa       (pa),
        .except   (tr_except)
    );

    always_comb begin
        case (kind_q)
            MEM_LD_B, MEM_LD_BU, MEM_ST_B: data_sram_size = SIZE_BYTE;
            MEM_LD_H, MEM_LD_HU, MEM_ST_H: data_sram_size = SIZE_HALF;
            default:                       data_sram_size = SIZE_WORD;
        endcase
    end

    assign misaligned = (data_sram_size == SIZE_HALF && alu_result[0])
                      || (data_sram_size == SIZE_WORD && alu_result[1:0] != 2'b00);

    // Misalignment is reported ahead of a translation miss
    always_comb begin
        if (!is_mem)
            out_except = EXC_NONE;
        else if (misaligned)
            out_except = EXC_ALE;
        else
            out_except = tr_except;
    end
    assign has_exc = (out_except != EXC_NONE);
    assign out_badv = alu_result;

    always_comb begin
        case (data_sram_size)
            SIZE_BYTE: data_sram_wstrb = 4'b0001 << alu_result[1:0];
            SIZE_HALF: data_sram_wstrb = alu_result[1] ? 4'b1100 : 4'b0011;
            default:   data_sram_wstrb = 4'b1111;
        endcase
        if (!is_store)
            data_sram_wstrb = 4'b0000;
        case (data_sram_size)
            SIZE_BYTE: data_sram_wdata = {4{store_q[7:0]}};
            SIZE_HALF: data_sram_wdata = {2{store_q[15:0]}};
            default:   data_sram_wdata = store_q;
        endcase
    end

    assign data_sram_req = valid & is_mem & ~has_exc & ~flush & mem_allow_in;
    assign data_sram_wr = is_store;
    assign data_sram_addr = pa;

    always_comb begin
        if (has_exc)
            ready_go = 1'b1;
        else if (is_div)
            ready_go = div_done | div_finished;
        else if (is_mul)
            ready_go = mul_ready;
        else if (is_mem)
            ready_go = data_sram_req & data_sram_addr_ok;
        else
            ready_go = 1'b1;
    end

    assign out_result = is_div ? div_result : is_mul ? mul_result : alu_result;
    assign out_valid = valid & ready_go & ~flush;
    assign allow_in = ~valid | (out_valid & mem_allow_in);

endmodule

`default_nettype wire

//--- addr_translate.sv
`default_nettype none
`timescale 1ns/100ps
`include "ex_consts.svh"

module addr_translate (
    input  logic [`EX_XLEN-1:0]     va,
    input  logic [`EX_XLEN-1:0]     csr_crmd,
    input  logic [`EX_XLEN-1:0]     csr_dmw0,
    input  logic [`EX_XLEN-1:0]     csr_dmw1,
    output logic [`EX_XLEN-1:0]     pa,
    output mem_access_pkg::ex_code_t except
);

    import mem_access_pkg::*;

    logic       direct;
    logic [1:0] plv;
    logic [2:0] vseg;
    logic       hit0;
    logic       hit1;

    assign direct = csr_crmd[`EX_CRMD_DA] & ~csr_crmd[`EX_CRMD_PG];
    assign plv = csr_crmd[`EX_CRMD_PLV_LSB +: 2];
    assign vseg = va[`EX_XLEN-1 -: 3];

    // Window must match the segment and allow the current privilege level
    assign hit0 = (csr_dmw0[`EX_DMW_VSEG_LSB +: 3] == vseg)
                & ((plv == 2'd0 & csr_dmw0[`EX_DMW_PLV0]) | (plv == 2'd3 & csr_dmw0[`EX_DMW_PLV3]));
    assign hit1 = (csr_dmw1[`EX_DMW_VSEG_LSB +: 3] == vseg)
                & ((plv == 2'd0 & csr_dmw1[`EX_DMW_PLV0]) | (plv == 2'd3 & csr_dmw1[`EX_DMW_PLV3]));

    always_comb begin
        pa = va;
        except = EXC_NONE;
        if (!direct) begin
            if (hit0)
                pa = {csr_dmw0[`EX_DMW_PSEG_LSB +: 3], va[`EX_XLEN-4:0]};
            else if (hit1)
                pa = {csr_dmw1[`EX_DMW_PSEG_LSB +: 3], va[`EX_XLEN-4:0]};
            else
                except = EXC_TLBR;
        end
    end

endmodule

`default_nettype wire

//--- divider.sv
`default_nettype none
`timescale 1ns/100ps
`include "ex_consts.svh"

module divider (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  ex_op_pkg::div_op_t  op,
    input  logic [`EX_XLEN-1:0] src1,
    input  logic [`EX_XLEN-1:0] src2,
    output logic [`EX_XLEN-1:0] result,
    output logic                done
);

    import ex_op_pkg::*;

    localparam int CNT_W = $clog2(`EX_DIV_STEPS) + 1;

    logic                 busy;
    logic [CNT_W-1:0]     count;
    logic                 is_signed;
    logic [`EX_XLEN-1:0]  mag1;
    logic [`EX_XLEN-1:0]  mag2;
    logic [`EX_XLEN-1:0]  quo;
    logic [`EX_XLEN-1:0]  rem;
    logic [`EX_XLEN-1:0]  divisor;
    logic [`EX_XLEN:0]    shifted;
    logic [`EX_XLEN:0]    diff;
    logic                 neg_q;
    logic                 neg_r;
    div_op_t              op_q;

    assign is_signed = (op == DIV_DIV) || (op == DIV_MOD);
    assign mag1 = (is_signed && src1[`EX_XLEN-1]) ? -src1 : src1;
    assign mag2 = (is_signed && src2[`EX_XLEN-1]) ? -src2 : src2;

    // Dividend bits shift out of quo into the partial remainder
    assign shifted = {rem, quo[`EX_XLEN-1]};
    assign diff = shifted - {1'b0, divisor};

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            count <= '0;
        end else begin
            done <= 1'b0;
            if (start && !busy) begin
                busy <= 1'b1;
                count <= '0;
            end else if (busy) begin
                count <= count + 1'b1;
                if (count == CNT_W'(`EX_DIV_STEPS - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            quo <= mag1;
            rem <= '0;
            divisor <= mag2;
            op_q <= op;
            // Zero divisor keeps the all-ones quotient unsigned
            neg_q <= is_signed & (src1[`EX_XLEN-1] ^ src2[`EX_XLEN-1]) & (|src2);
            neg_r <= is_signed & src1[`EX_XLEN-1];
        end else if (busy) begin
            quo <= {quo[`EX_XLEN-2:0], ~diff[`EX_XLEN]};
            rem <= diff[`EX_XLEN] ? shifted[`EX_XLEN-1:0] : diff[`EX_XLEN-1:0];
        end
    end

    always_comb begin
        if (op_q == DIV_MOD || op_q == DIV_MODU)
            result = neg_r ? -rem : rem;
        else
            result = neg_q ? -quo : quo;
    end

endmodule

`default_nettype wire

//--- multiplier.sv
`default_nettype none
`timescale 1ns/100ps
`include "ex_consts.svh"

module multiplier (
    input  logic                clk,
    input  ex_op_pkg::mul_op_t  op,
    input  logic [`EX_XLEN-1:0] src1,
    input  logic [`EX_XLEN-1:0] src2,
    output logic [`EX_XLEN-1:0] result
);

    import ex_op_pkg::*;

    logic                          sign_ext;
    logic signed [`EX_XLEN:0]      a_ext;
    logic signed [`EX_XLEN:0]      b_ext;
    logic signed [2*`EX_XLEN+1:0]  product;

    // Extra operand bit turns unsigned into signed multiply
    assign sign_ext = (op == MUL_HI);
    assign a_ext = {sign_ext & src1[`EX_XLEN-1], src1};
    assign b_ext = {sign_ext & src2[`EX_XLEN-1], src2};
    assign product = a_ext * b_ext;

    always_ff @(posedge clk) begin
        if (op == MUL_HI || op == MUL_HIU)
            result <= product[2*`EX_XLEN-1:`EX_XLEN];
        else
            result <= product[`EX_XLEN-1:0];
    end

endmodule

`default_nettype wire

//--- alu.sv
`default_nettype none
`timescale 1ns/100ps
`include "ex_consts.svh"

module alu (
    input  ex_op_pkg::alu_op_t  alu_op,
    input  logic [`EX_XLEN-1:0] src1,
    input  logic [`EX_XLEN-1:0] src2,
    output logic [`EX_XLEN-1:0] result
);

    import ex_op_pkg::*;

    logic                sub_mode;
    logic [`EX_XLEN:0]   sum;
    logic                slt;
    logic                sltu;
    logic [4:0]          shamt;

    // One adder serves add, sub and both compares
    assign sub_mode = (alu_op == ALU_SUB) || (alu_op == ALU_SLT) || (alu_op == ALU_SLTU);
    assign sum = {1'b0, src1} + {1'b0, sub_mode ? ~src2 : src2} + {{`EX_XLEN{1'b0}}, sub_mode};

    assign slt = (src1[`EX_XLEN-1] & ~src2[`EX_XLEN-1])
               | (~(src1[`EX_XLEN-1] ^ src2[`EX_XLEN-1]) & sum[`EX_XLEN-1]);
    // No carry out of a - b means a < b
    assign sltu = ~sum[`EX_XLEN];

    assign shamt = src2[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD,
            ALU_SUB:   result = sum[`EX_XLEN-1:0];
            ALU_SLT:   result = {{(`EX_XLEN-1){1'b0}}, slt};
            ALU_SLTU:  result = {{(`EX_XLEN-1){1'b0}}, sltu};
            ALU_AND:   result = src1 & src2;
            ALU_OR:    result = src1 | src2;
            ALU_NOR:   result = ~(src1 | src2);
            ALU_XOR:   result = src1 ^ src2;
            ALU_SLL:   result = src1 << shamt;
            ALU_SRL:   result = src1 >> shamt;
            ALU_SRA:   result = $signed(src1) >>> shamt;
            // Immediate arrives already shifted in src2
            ALU_LU12I: result = src2;
            default:   result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- mem_access_pkg.sv
`default_nettype none

package mem_access_pkg;

    // Nine kinds, so four bits are needed
    typedef enum logic [3:0] {
        MEM_NONE  = 4'd0,
        MEM_LD_B  = 4'd1,
        MEM_LD_BU = 4'd2,
        MEM_LD_H  = 4'd3,
        MEM_LD_HU = 4'd4,
        MEM_LD_W  = 4'd5,
        MEM_ST_B  = 4'd6,
        MEM_ST_H  = 4'd7,
        MEM_ST_W  = 4'd8
    } mem_kind_t;

    // Encoding as seen on data_sram_size
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_t;

    typedef enum logic [1:0] {
        EXC_NONE = 2'd0,
        EXC_ALE  = 2'd1,
        EXC_TLBR = 2'd2
    } ex_code_t;

endpackage

`default_nettype wire

//--- ex_op_pkg.sv
`default_nettype none

package ex_op_pkg;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLT   = 4'd2,
        ALU_SLTU  = 4'd3,
        ALU_AND   = 4'd4,
        ALU_OR    = 4'd5,
        ALU_NOR   = 4'd6,
        ALU_XOR   = 4'd7,
        ALU_SLL   = 4'd8,
        ALU_SRL   = 4'd9,
        ALU_SRA   = 4'd10,
        ALU_LU12I = 4'd11
    } alu_op_t;

    // mulh takes the upper half of the product
    typedef enum logic [1:0] {
        MUL_NONE = 2'd0,
        MUL_LO   = 2'd1,
        MUL_HI   = 2'd2,
        MUL_HIU  = 2'd3
    } mul_op_t;

    typedef enum logic [2:0] {
        DIV_NONE = 3'd0,
        DIV_DIV  = 3'd1,
        DIV_MOD  = 3'd2,
        DIV_DIVU = 3'd3,
        DIV_MODU = 3'd4
    } div_op_t;

endpackage

`default_nettype wire

//--- ex_consts.svh
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// Datapath and address width
`define EX_XLEN 32
`define EX_DIV_STEPS 32

// CRMD fields
`define EX_CRMD_PLV_LSB 0
`define EX_CRMD_DA 3
`define EX_CRMD_PG 4

// DMW fields
`define EX_DMW_PLV0 0
`define EX_DMW_PLV3 3
`define EX_DMW_PSEG_LSB 25
`define EX_DMW_VSEG_LSB 29

`endif
